/* all.f */
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/pipe_reg.sv
rtl/cpu_ctrl_regs.sv
rtl/fetch.sv
rtl/decode_reg_r.sv
rtl/execute.sv
rtl/cpu.sv
dv/cpu_tb.sv

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

  localparam int clk_period = 4;
  localparam int hs_limit   = 16; // cycles allowed for one ready or valid.
  localparam int max_delay  = 8;
  localparam int run_bound  = 4 * `CPU_IMEM_DEPTH + 20; // longest possible program.
  localparam int axi_ops    = 400;
  localparam int axi_cycles = 2 * hs_limit + max_delay + 4;
  localparam int wd_cycles  = 3 * run_bound + 4 * 10 + axi_ops * axi_cycles;

  localparam int sel_aw = 0;
  localparam int sel_b  = 1;
  localparam int sel_ar = 2;
  localparam int sel_r  = 3;

  localparam logic [3:0] c_eq = cpu_isa_pkg::cond_eq;
  localparam logic [3:0] c_ne = cpu_isa_pkg::cond_ne;
  localparam logic [3:0] c_al = cpu_isa_pkg::cond_al;
  localparam logic [3:0] c_gt = 4'b1100; // outside the supported set.
  localparam logic [3:0] o_and = cpu_isa_pkg::op_and;
  localparam logic [3:0] o_sub = cpu_isa_pkg::op_sub;
  localparam logic [3:0] o_add = cpu_isa_pkg::op_add;
  localparam logic [3:0] o_cmp = cpu_isa_pkg::op_cmp;
  localparam logic [3:0] o_orr = cpu_isa_pkg::op_orr;
  localparam logic [3:0] o_mov = cpu_isa_pkg::op_mov;

  logic                   clk_i;
  logic                   rst_n_i;
  cpu_bus_pkg::axil_req_t req;
  cpu_bus_pkg::axil_rsp_t rsp;

  cpu_isa_pkg::word_t prog [$];
  cpu_isa_pkg::word_t model_rf [`CPU_NREGS];
  logic               model_z;
  cpu_isa_pkg::word_t last_rdata;
  cpu_bus_pkg::resp_e last_rresp;
  cpu_bus_pkg::resp_e last_bresp;
  int                 errors;
  int                 tests_run;
  int                 tests_failed;

  cpu cpu_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .axil_req_i(req),
    .axil_rsp_o(rsp)
  );

  initial clk_i = 1'b0;
  always #(clk_period / 2) clk_i = ~clk_i;

  bvalid_kept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp.bvalid && !req.bready |=> rsp.bvalid)
    else begin
      $display("MISMATCH at %0t: bvalid got 0 expected 1", $time);
      errors++;
    end

  rvalid_kept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp.rvalid && !req.rready |=> rsp.rvalid)
    else begin
      $display("MISMATCH at %0t: rvalid got 0 expected 1", $time);
      errors++;
    end

  rdata_kept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp.rvalid && !req.rready |=> $stable(rsp.rdata))
    else begin
      $display("%0t: rdata changed while the read response was waiting", $time);
      errors++;
    end

  no_write_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp.bvalid |-> !rsp.awready && !rsp.wready)
    else begin
      $display("%0t: a write was accepted while a write response was pending", $time);
      errors++;
    end

  no_read_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp.rvalid |-> !rsp.arready)
    else begin
      $display("%0t: a read was accepted while a read response was pending", $time);
      errors++;
    end

  // the two slots behind a taken branch are squashed.
  flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpu_i.branch_taken |=> (!cpu_i.rf_wr.en) [*2])
    else begin
      $display("%0t: a register was written right after a taken branch", $time);
      errors++;
    end

  function automatic cpu_isa_pkg::word_t encode_dp(input logic [3:0] cond,
      input logic [3:0] op, input logic s, input logic imm_sel,
      input logic [3:0] rd, input logic [3:0] rn, input logic [7:0] op2);
    logic [7:0] low;
    low = imm_sel ? op2 : {4'b0000, op2[3:0]}; // rm sits in bits 3:0.
    return {cond, 2'b00, imm_sel, op, s, rn, rd, 4'b0000, low};
  endfunction

  function automatic cpu_isa_pkg::word_t encode_branch(input logic [3:0] cond,
                                                       input logic [23:0] offset);
    return {cond, 4'b1010, offset};
  endfunction

  function automatic cpu_isa_pkg::word_t fill_word(input int i);
    return {8'(i), 8'(~i), 8'(i * 37), 8'(i ^ 8'h5a)};
  endfunction

  function automatic cpu_bus_pkg::axil_addr_t imem_addr(input int i);
    return cpu_bus_pkg::axil_addr_t'(`CPU_ADDR_IMEM_BASE + 4 * i);
  endfunction

  function automatic logic rsp_bit(input int sel);
    case (sel)
      sel_aw:  return rsp.awready && rsp.wready;
      sel_b:   return rsp.bvalid;
      sel_ar:  return rsp.arready;
      default: return rsp.rvalid;
    endcase
  endfunction

  task automatic check_word(input string name, input cpu_isa_pkg::word_t got,
                            input cpu_isa_pkg::word_t exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // returns on the edge where the signal was seen high.
  task automatic await_high(input int sel, input string what);
    int   n;
    logic seen;
    n = 0;
    do begin
      @(negedge clk_i);
      seen = rsp_bit(sel);
      if (seen && sel == sel_r) begin
        last_rdata = rsp.rdata;
        last_rresp = rsp.rresp;
      end
      if (seen && sel == sel_b) last_bresp = rsp.bresp;
      @(posedge clk_i);
      n++;
    end while (!seen && n < hs_limit);
    if (!seen) begin
      $display("%0t: %s never came within %0d cycles", $time, what, hs_limit);
      errors++;
    end
  endtask

  task automatic axil_write(input cpu_bus_pkg::axil_addr_t addr,
                            input cpu_isa_pkg::word_t data);
    int delay;
    delay = $urandom % max_delay;
    req.awaddr  = addr;
    req.wdata   = data;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    await_high(sel_aw, "awready and wready");
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    idle_cycles(delay); // response waits on a late bready.
    req.bready = 1'b1;
    await_high(sel_b, "bvalid");
    #1 req.bready = 1'b0;
    check_word("bresp", cpu_isa_pkg::word_t'(last_bresp),
               cpu_isa_pkg::word_t'(cpu_bus_pkg::resp_okay));
  endtask

  task automatic read_check(input cpu_bus_pkg::axil_addr_t addr,
                            input cpu_isa_pkg::word_t exp, input string name);
    int delay;
    delay = $urandom % max_delay;
    req.araddr  = addr;
    req.arvalid = 1'b1;
    await_high(sel_ar, "arready");
    #1 req.arvalid = 1'b0;
    idle_cycles(delay);
    req.rready = 1'b1;
    await_high(sel_r, "rvalid");
    #1 req.rready = 1'b0;
    check_word(name, last_rdata, exp);
    check_word("rresp", cpu_isa_pkg::word_t'(last_rresp),
               cpu_isa_pkg::word_t'(cpu_bus_pkg::resp_okay));
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    idle_cycles(10);
    rst_n_i = 1'b1;
    model_z = 1'b0; // cpsr clears with the core.
  endtask

  task automatic model_dp(input cpu_isa_pkg::word_t ins);
    cpu_isa_pkg::word_t a;
    cpu_isa_pkg::word_t b;
    cpu_isa_pkg::word_t res;
    logic               wr;
    logic               known;
    a = model_rf[ins[19:16]];
    b = ins[25] ? cpu_isa_pkg::word_t'(ins[7:0]) : model_rf[ins[3:0]];
    wr = 1'b1;
    known = 1'b1;
    case (ins[24:21])
      4'b0000: res = a & b;
      4'b0010: res = a - b;
      4'b0100: res = a + b;
      4'b1010: begin
        res = a - b;
        wr = 1'b0; // compare only.
      end
      4'b1100: res = a | b;
      4'b1101: res = b;
      default: begin
        res = '0;
        wr = 1'b0;
        known = 1'b0;
      end
    endcase
    if (known && (!wr || ins[20])) begin
      model_z = (res == '0);
    end
    if (wr) model_rf[ins[15:12]] = res;
  endtask

  // sequential run of prog until it reaches a branch to itself.
  task automatic model_program();
    int unsigned        pc;
    cpu_isa_pkg::word_t ins;
    cpu_isa_pkg::word_t target;
    logic               ok;
    pc = 0;
    for (int step = 0; step < 4 * `CPU_IMEM_DEPTH; step++) begin
      ins = prog[pc / 4];
      case (ins[31:28])
        4'b0000: ok = model_z;
        4'b0001: ok = !model_z;
        4'b1110: ok = 1'b1;
        default: ok = 1'b0;
      endcase
      if (ins[27:26] == 2'b10) begin
        target = pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
        if (ok && target == pc) break;
        pc = (ok ? target : pc + 4) % (4 * `CPU_IMEM_DEPTH);
      end else begin
        if (ins[27:26] == 2'b00 && ok) model_dp(ins);
        pc = (pc + 4) % (4 * `CPU_IMEM_DEPTH);
      end
    end
  endtask

  task automatic finish_test(input int num, input string name, input int mark);
    tests_run++;
    if (errors == mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - mark);
    end
  endtask

  task automatic run_program(input int num, input string name);
    int mark;
    mark = errors;
    apply_reset();
    foreach (prog[i]) axil_write(imem_addr(i), prog[i]);
    model_program();
    axil_write(`CPU_ADDR_CTRL, 32'd1);
    idle_cycles(4 * prog.size() + 20);
    axil_write(`CPU_ADDR_CTRL, 32'd0);
    idle_cycles(4); // drain.
    for (int r = 0; r < `CPU_NREGS; r++) begin
      read_check(cpu_bus_pkg::axil_addr_t'(`CPU_ADDR_REG_BASE + 4 * r), model_rf[r],
                 $sformatf("r%0d", r));
    end
    finish_test(num, name, mark);
  endtask

  task automatic build_random();
    logic [3:0] cond;
    logic [3:0] op;
    prog.delete();
    for (int i = 0; i < 30; i++) begin
      case ($urandom % 5)
        0: cond = c_eq;
        1: cond = c_ne;
        4: cond = c_gt;
        default: cond = c_al;
      endcase
      case ($urandom % 7)
        0: op = o_and;
        1: op = o_sub;
        2: op = o_add;
        3: op = o_cmp;
        4: op = o_orr;
        5: op = o_mov;
        default: op = 4'b0111; // unused code that acts as a no-op.
      endcase
      prog.push_back(encode_dp(cond, op, 1'($urandom), 1'($urandom), 4'($urandom),
                               4'($urandom), 8'($urandom)));
    end
    prog.push_back(encode_branch(c_al, 24'hfffffe));
  endtask

  initial begin
    repeat (wd_cycles) @(posedge clk_i);
    $display("watchdog: the run did not end within %0d cycles", wd_cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int  mark;
    time t0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    req = '0;
    req.wstrb = '1;
    rst_n_i = 1'b0;
    foreach (model_rf[r]) model_rf[r] = '0;
    void'($urandom(32'h9a061595));
    apply_reset();

    mark = errors;
    t0 = $time;
    while ($time - t0 < 20 * clk_period) read_check(`CPU_ADDR_PC, '0, "pc");
    read_check(`CPU_ADDR_CTRL, '0, "ctrl");
    finish_test(1, "reset state", mark);

    mark = errors;
    for (int i = 0; i < `CPU_IMEM_DEPTH; i++) axil_write(imem_addr(i), fill_word(i));
    for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
      read_check(imem_addr(i), fill_word(i), $sformatf("imem[%0d]", i));
    end
    read_check(12'h200, '0, "unmapped");
    finish_test(2, "imem readback", mark);

    // every register gets a value before the dependent chain.
    prog.delete();
    for (int r = 0; r < 16; r++) prog.push_back(encode_dp(c_al, o_mov, 0, 1, r, 0, r * 7 + 3));
    prog.push_back(encode_dp(c_al, o_add, 0, 1, 1, 0, 5));
    prog.push_back(encode_dp(c_al, o_add, 0, 0, 2, 1, 1));
    prog.push_back(encode_dp(c_al, o_sub, 0, 1, 3, 2, 1));
    prog.push_back(encode_dp(c_al, o_and, 0, 0, 4, 3, 2));
    prog.push_back(encode_dp(c_al, o_orr, 0, 1, 5, 4, 8'h80));
    prog.push_back(encode_dp(c_al, o_mov, 0, 0, 6, 0, 5));
    prog.push_back(encode_dp(c_al, o_sub, 0, 0, 7, 6, 1));
    prog.push_back(encode_dp(c_al, o_orr, 0, 0, 8, 7, 3));
    prog.push_back(encode_dp(c_al, o_and, 0, 1, 9, 8, 8'hf0));
    prog.push_back(encode_dp(c_al, o_add, 0, 0, 15, 9, 9));
    prog.push_back(encode_branch(c_al, 24'hfffffe));
    run_program(3, "dependent chain");

    prog.delete();
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 0, 0, 5));
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 1, 0, 5));
    prog.push_back(encode_dp(c_al, o_cmp, 1, 0, 0, 0, 1));
    prog.push_back(encode_branch(c_eq, 24'd1));          // taken.
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 2, 0, 8'haa));
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 3, 0, 8'hbb));
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 4, 0, 1));
    prog.push_back(encode_branch(c_ne, 24'd0));          // not taken.
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 5, 0, 2));
    prog.push_back(encode_dp(c_ne, o_mov, 0, 1, 6, 0, 3));
    prog.push_back(encode_dp(c_eq, o_mov, 0, 1, 7, 0, 4));
    prog.push_back(encode_dp(c_al, o_cmp, 1, 1, 0, 0, 6));
    prog.push_back(encode_branch(c_eq, 24'd1));
    prog.push_back(encode_branch(c_ne, 24'd1));
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 8, 0, 8'h11));
    prog.push_back(encode_dp(c_al, o_mov, 0, 1, 9, 0, 8'h22));
    prog.push_back(encode_dp(c_ne, o_mov, 0, 1, 10, 0, 8'h33));
    prog.push_back(encode_dp(c_eq, o_add, 0, 1, 11, 11, 1));
    prog.push_back(encode_dp(c_al, o_sub, 1, 1, 12, 0, 5));
    prog.push_back(encode_dp(c_eq, o_mov, 0, 1, 13, 0, 8'h44));
    prog.push_back(encode_dp(c_gt, o_mov, 0, 1, 14, 0, 8'h55));
    prog.push_back(encode_branch(c_al, 24'hfffffe));
    run_program(4, "branches and conditions");

    build_random();
    run_program(5, "random program");

    // responses held back while a second request waits.
    mark = errors;
    req.awaddr  = 12'h300;
    req.wdata   = 32'h1111_1111;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    await_high(sel_aw, "awready and wready");
    #1 req.wdata = 32'h2222_2222;
    idle_cycles(6);
    req.bready = 1'b1;
    await_high(sel_b, "bvalid");
    #1;
    await_high(sel_aw, "awready and wready");
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    await_high(sel_b, "bvalid");
    #1 req.bready = 1'b0;
    req.araddr  = `CPU_ADDR_PC;
    req.arvalid = 1'b1;
    await_high(sel_ar, "arready");
    #1 req.araddr = `CPU_ADDR_CTRL;
    idle_cycles(6);
    req.rready = 1'b1;
    await_high(sel_r, "rvalid");
    #1;
    await_high(sel_ar, "arready");
    #1 req.arvalid = 1'b0;
    await_high(sel_r, "rvalid");
    #1 req.rready = 1'b0;
    check_word("ctrl", last_rdata, '0);
    finish_test(6, "response back-pressure", mark);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rtl/cpu.sv */
`timescale 1ns/1ps

module cpu (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  cpu_bus_pkg::axil_req_t axil_req_i,
  output cpu_bus_pkg::axil_rsp_t axil_rsp_o
);

  logic                     run;
  logic                     imem_we;
  cpu_isa_pkg::imem_addr_t  imem_waddr;
  cpu_isa_pkg::word_t       imem_wdata;
  cpu_isa_pkg::word_t       pc;
  cpu_isa_pkg::reg_addr_t   dbg_raddr;
  cpu_isa_pkg::word_t       dbg_rdata;
  logic                     fetch_valid;
  cpu_isa_pkg::fd_payload_t fetch_data;
  logic                     fd_valid;
  cpu_isa_pkg::fd_payload_t fd_data;
  logic                     decode_valid;
  cpu_isa_pkg::de_payload_t decode_data;
  logic                     de_valid;
  cpu_isa_pkg::de_payload_t de_data;
  cpu_isa_pkg::rf_wr_t      rf_wr;
  logic                     branch_taken;
  cpu_isa_pkg::word_t       branch_target;
  logic                     flush;

  cpu_ctrl_regs ctrl_regs (
      .clk_i(clk_i), .rst_n_i(rst_n_i)
    , .axil_req_i(axil_req_i), .axil_rsp_o(axil_rsp_o)
    , .run_o(run), .imem_we_o(imem_we), .imem_waddr_o(imem_waddr)
    , .imem_wdata_o(imem_wdata), .pc_i(pc)
    , .dbg_raddr_o(dbg_raddr), .dbg_rdata_i(dbg_rdata)
  );

  fetch fetch_stage (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .run_i(run)
    , .imem_we_i(imem_we), .imem_waddr_i(imem_waddr), .imem_wdata_i(imem_wdata)
    , .branch_taken_i(branch_taken), .branch_target_i(branch_target)
    , .fd_valid_o(fetch_valid), .fd_o(fetch_data), .pc_o(pc)
  );

  pipe_reg #(.payload_t(cpu_isa_pkg::fd_payload_t)) fd_reg (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(fetch_valid), .data_i(fetch_data)
    , .flush_i(flush), .valid_o(fd_valid), .data_o(fd_data)
  );

  decode_reg_r decode_stage (
      .clk_i(clk_i), .fd_valid_i(fd_valid), .fd_i(fd_data), .rf_wr_i(rf_wr)
    , .dbg_raddr_i(dbg_raddr), .dbg_rdata_o(dbg_rdata)
    , .de_valid_o(decode_valid), .de_o(decode_data)
  );

  pipe_reg #(.payload_t(cpu_isa_pkg::de_payload_t)) de_reg (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(decode_valid), .data_i(decode_data)
    , .flush_i(flush), .valid_o(de_valid), .data_o(de_data)
  );

  execute execute_stage (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .de_valid_i(de_valid), .de_i(de_data)
    , .rf_wr_o(rf_wr), .branch_taken_o(branch_taken)
    , .branch_target_o(branch_target), .flush_o(flush)
  );

endmodule

/* rtl/execute.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     de_valid_i,
  input  cpu_isa_pkg::de_payload_t de_i,
  output cpu_isa_pkg::rf_wr_t      rf_wr_o,
  output logic                     branch_taken_o,
  output cpu_isa_pkg::word_t       branch_target_o,
  output logic                     flush_o
);

  cpu_isa_pkg::flags_t cpsr_q;
  cpu_isa_pkg::word_t  op2;
  cpu_isa_pkg::word_t  alu_res;
  logic                cond_met;
  logic                writes_rd;
  logic                sets_flags;
  logic                dp_fire;

  always_comb begin
    case (de_i.instr.cond)
      cpu_isa_pkg::cond_eq: cond_met = cpsr_q.z;
      cpu_isa_pkg::cond_ne: cond_met = !cpsr_q.z;
      cpu_isa_pkg::cond_al: cond_met = 1'b1;
      default:              cond_met = 1'b0; // unsupported codes never pass.
    endcase
  end

  assign op2 = de_i.instr.imm_sel ? cpu_isa_pkg::word_t'(de_i.instr.imm8) : de_i.op_b;

  always_comb begin
    alu_res   = '0;
    writes_rd = 1'b1;
    case (de_i.instr.opcode)
      cpu_isa_pkg::op_and: alu_res = de_i.op_a & op2;
      cpu_isa_pkg::op_sub: alu_res = de_i.op_a - op2;
      cpu_isa_pkg::op_add: alu_res = de_i.op_a + op2;
      cpu_isa_pkg::op_orr: alu_res = de_i.op_a | op2;
      cpu_isa_pkg::op_mov: alu_res = op2;
      cpu_isa_pkg::op_cmp: begin
        alu_res   = de_i.op_a - op2;
        writes_rd = 1'b0;
      end
      default: writes_rd = 1'b0;
    endcase
  end

  // cmp always updates flags, the rest only with s.
  assign sets_flags = (de_i.instr.opcode == cpu_isa_pkg::op_cmp) ||
                      (de_i.instr.s && writes_rd);
  assign dp_fire    = de_valid_i && cond_met && !de_i.instr.is_branch;

  assign rf_wr_o.en   = dp_fire && writes_rd;
  assign rf_wr_o.addr = de_i.instr.rd;
  assign rf_wr_o.data = alu_res;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cpsr_q <= '0;
    end else if (dp_fire && sets_flags) begin
      cpsr_q.n <= alu_res[`CPU_XLEN-1];
      cpsr_q.z <= (alu_res == '0);
    end
  end

  assign branch_taken_o  = de_valid_i && cond_met && de_i.instr.is_branch;
  assign branch_target_o = de_i.pc + 8 +
                           {{(`CPU_XLEN-26){de_i.instr.offset[23]}}, de_i.instr.offset, 2'b00};
  assign flush_o         = branch_taken_o; // kills the two younger instructions.

  no_effect_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rf_wr_o.en || branch_taken_o) |-> de_valid_i);

endmodule

/* rtl/decode_reg_r.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_reg_r (
  input  logic                     clk_i,
  input  logic                     fd_valid_i,
  input  cpu_isa_pkg::fd_payload_t fd_i,
  input  cpu_isa_pkg::rf_wr_t      rf_wr_i,
  input  cpu_isa_pkg::reg_addr_t   dbg_raddr_i,
  output cpu_isa_pkg::word_t       dbg_rdata_o,
  output logic                     de_valid_o,
  output cpu_isa_pkg::de_payload_t de_o
);

  cpu_isa_pkg::word_t      rf [`CPU_NREGS];
  cpu_isa_pkg::dec_instr_t dec;
  cpu_isa_pkg::word_t      rn_val;
  cpu_isa_pkg::word_t      rm_val;

  always_comb begin
    dec.cond      = cpu_isa_pkg::cond_e'(fd_i.instr[31:28]);
    dec.is_branch = (fd_i.instr[27:26] == 2'b10);
    dec.imm_sel   = fd_i.instr[25];
    dec.rn        = fd_i.instr[19:16];
    dec.rd        = fd_i.instr[15:12];
    dec.rm        = fd_i.instr[3:0];
    dec.imm8      = fd_i.instr[7:0];
    dec.offset    = fd_i.instr[23:0];
    if (fd_i.instr[27:26] == 2'b00) begin
      dec.opcode = cpu_isa_pkg::opcode_e'(fd_i.instr[24:21]);
      dec.s      = fd_i.instr[20];
    end else begin
      // other classes turn into an unused opcode.
      dec.opcode = cpu_isa_pkg::opcode_e'(4'b1111);
      dec.s      = 1'b0;
    end
  end

  // same-cycle write from execute is forwarded.
  assign rn_val = (rf_wr_i.en && rf_wr_i.addr == dec.rn) ? rf_wr_i.data : rf[dec.rn];
  assign rm_val = (rf_wr_i.en && rf_wr_i.addr == dec.rm) ? rf_wr_i.data : rf[dec.rm];

  always_ff @(posedge clk_i) begin
    if (rf_wr_i.en) rf[rf_wr_i.addr] <= rf_wr_i.data;
  end

  assign dbg_rdata_o = rf[dbg_raddr_i];

  assign de_valid_o = fd_valid_i;
  assign de_o.instr = dec;
  assign de_o.op_a  = rn_val;
  assign de_o.op_b  = rm_val;
  assign de_o.pc    = fd_i.pc;

endmodule

/* rtl/fetch.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     run_i,
  input  logic                     imem_we_i,
  input  cpu_isa_pkg::imem_addr_t  imem_waddr_i,
  input  cpu_isa_pkg::word_t       imem_wdata_i,
  input  logic                     branch_taken_i,
  input  cpu_isa_pkg::word_t       branch_target_i,
  output logic                     fd_valid_o,
  output cpu_isa_pkg::fd_payload_t fd_o,
  output cpu_isa_pkg::word_t       pc_o
);

  localparam int unsigned imem_aw = $bits(cpu_isa_pkg::imem_addr_t);

  cpu_isa_pkg::word_t      imem [`CPU_IMEM_DEPTH];
  cpu_isa_pkg::imem_addr_t pc_idx_q; // word index, wraps at the memory end.

  always_ff @(posedge clk_i) begin
    if (imem_we_i) imem[imem_waddr_i] <= imem_wdata_i;
  end

  // a redirect wins over halt so draining branches still land.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_idx_q <= '0;
    end else if (branch_taken_i) begin
      pc_idx_q <= branch_target_i[imem_aw+1:2];
    end else if (run_i) begin
      pc_idx_q <= pc_idx_q + 1'b1;
    end
  end

  assign pc_o       = cpu_isa_pkg::word_t'({pc_idx_q, 2'b00});
  assign fd_valid_o = run_i;
  assign fd_o.instr = imem[pc_idx_q]; // asynchronous read.
  assign fd_o.pc    = pc_o;

endmodule

/* rtl/cpu_ctrl_regs.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  cpu_bus_pkg::axil_req_t  axil_req_i,
  output cpu_bus_pkg::axil_rsp_t  axil_rsp_o,
  output logic                    run_o,
  output logic                    imem_we_o,
  output cpu_isa_pkg::imem_addr_t imem_waddr_o,
  output cpu_isa_pkg::word_t      imem_wdata_o,
  input  cpu_isa_pkg::word_t      pc_i,
  output cpu_isa_pkg::reg_addr_t  dbg_raddr_o,
  input  cpu_isa_pkg::word_t      dbg_rdata_i
);

  localparam int unsigned imem_aw = $bits(cpu_isa_pkg::imem_addr_t);
  localparam int unsigned reg_aw  = $bits(cpu_isa_pkg::reg_addr_t);

  logic               run_q;
  logic               bvalid_q;
  logic               rvalid_q;
  logic               wr_hs;
  logic               rd_hs;
  cpu_isa_pkg::word_t rdata_q;
  cpu_isa_pkg::word_t rd_mux;
  cpu_isa_pkg::word_t imem_shadow [`CPU_IMEM_DEPTH]; // host-side copy for readback.

  function automatic logic in_window(input cpu_bus_pkg::axil_addr_t addr,
                                     input cpu_bus_pkg::axil_addr_t base,
                                     input int unsigned words);
    return (addr >= base) && (int'(addr) < int'(base) + words * 4);
  endfunction

  // one write and one read outstanding at most.
  assign wr_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_hs = axil_req_i.arvalid && !rvalid_q;

  assign axil_rsp_o.awready = wr_hs;
  assign axil_rsp_o.wready  = wr_hs;
  assign axil_rsp_o.bresp   = cpu_bus_pkg::resp_okay;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.arready = !rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = cpu_bus_pkg::resp_okay;
  assign axil_rsp_o.rvalid  = rvalid_q;

  assign run_o        = run_q;
  assign imem_we_o    = wr_hs && in_window(axil_req_i.awaddr, `CPU_ADDR_IMEM_BASE,
                                           `CPU_IMEM_DEPTH);
  assign imem_waddr_o = axil_req_i.awaddr[imem_aw+1:2];
  assign imem_wdata_o = axil_req_i.wdata; // strobes ignored.
  assign dbg_raddr_o  = axil_req_i.araddr[reg_aw+1:2];

  always_comb begin
    rd_mux = '0; // unmapped reads return zero.
    if (axil_req_i.araddr == `CPU_ADDR_CTRL) begin
      rd_mux = cpu_isa_pkg::word_t'(run_q);
    end else if (axil_req_i.araddr == `CPU_ADDR_PC) begin
      rd_mux = pc_i;
    end else if (in_window(axil_req_i.araddr, `CPU_ADDR_REG_BASE, `CPU_NREGS)) begin
      rd_mux = dbg_rdata_i;
    end else if (in_window(axil_req_i.araddr, `CPU_ADDR_IMEM_BASE, `CPU_IMEM_DEPTH)) begin
      rd_mux = imem_shadow[axil_req_i.araddr[imem_aw+1:2]];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q    <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs && axil_req_i.awaddr == `CPU_ADDR_CTRL) begin
        run_q <= axil_req_i.wdata[0];
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs) rdata_q <= rd_mux;
    if (imem_we_o) imem_shadow[imem_waddr_o] <= axil_req_i.wdata;
  end

  bvalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

  rvalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_o.rvalid && !axil_req_i.rready |=>
      axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata));

endmodule

/* rtl/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  input  logic     flush_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i && !flush_i; // a flush kills whatever is entering.
    end
  end

  always_ff @(posedge clk_i) begin
    data_o <= data_i;
  end

  flush_kills_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !valid_o);

endmodule

/* rtl/cpu_bus_pkg.sv */
`include "cpu_settings.svh"

package cpu_bus_pkg;

  typedef logic [`CPU_AXI_AW-1:0] axil_addr_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_e;

  // host to slave.
  typedef struct packed {
    axil_addr_t              awaddr;
    logic                    awvalid;
    logic [`CPU_XLEN-1:0]    wdata;
    logic [`CPU_XLEN/8-1:0]  wstrb;
    logic                    wvalid;
    logic                    bready;
    axil_addr_t              araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_t;

  // slave to host.
  typedef struct packed {
    logic                 awready;
    logic                 wready;
    resp_e                bresp;
    logic                 bvalid;
    logic                 arready;
    logic [`CPU_XLEN-1:0] rdata;
    resp_e                rresp;
    logic                 rvalid;
  } axil_rsp_t;

endpackage

/* rtl/cpu_isa_pkg.sv */
`include "cpu_settings.svh"

package cpu_isa_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_addr_t;
  typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_addr_t;

  // data-processing codes, anything else is a no-op.
  typedef enum logic [3:0] {
    op_and = 4'b0000,
    op_sub = 4'b0010,
    op_add = 4'b0100,
    op_cmp = 4'b1010,
    op_orr = 4'b1100,
    op_mov = 4'b1101
  } opcode_e;

  typedef enum logic [3:0] {
    cond_eq = 4'b0000,
    cond_ne = 4'b0001,
    cond_al = 4'b1110
  } cond_e;

  typedef struct packed {
    logic n;
    logic z;
  } flags_t;

  typedef struct packed {
    cond_e       cond;
    opcode_e     opcode;
    logic        is_branch;
    logic        s;
    logic        imm_sel;
    reg_addr_t   rd;
    reg_addr_t   rn;
    reg_addr_t   rm;
    logic [7:0]  imm8;
    logic [23:0] offset;
  } dec_instr_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } fd_payload_t;

  typedef struct packed {
    dec_instr_t instr;
    word_t      op_a; // rn value.
    word_t      op_b; // rm value.
    word_t      pc;
  } de_payload_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

endpackage

/* rtl/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// core dimensions.
`define CPU_XLEN       32
`define CPU_NREGS      16
`define CPU_IMEM_DEPTH 64

// AXI4-Lite byte address map, 12-bit addresses.
`define CPU_AXI_AW         12
`define CPU_ADDR_CTRL      12'h000 // bit 0 is run.
`define CPU_ADDR_PC        12'h004
`define CPU_ADDR_REG_BASE  12'h040 // one word per register.
`define CPU_ADDR_IMEM_BASE 12'h400 // one word per instruction.

`endif
